// ==== Bender.yml ====
package:
  name: sdspi

sources:
  - logic/host_pkg.sv
  - logic/sd_pkg.sv
  - logic/sector_buffer.sv
  - logic/spi_link.sv
  - logic/sd_sequencer.sv
  - logic/sdspi_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/sd_card_model.sv
      - verif/sdspi_assert.sv
      - verif/tb_sdspi.sv

// ==== files.f ====
logic/host_pkg.sv
logic/sd_pkg.sv
logic/sector_buffer.sv
logic/spi_link.sv
logic/sd_sequencer.sv
logic/sdspi_top.sv
verif/tb_clock.sv
verif/sd_card_model.sv
verif/sdspi_assert.sv
verif/tb_sdspi.sv

// ==== logic/host_pkg.sv ====
//**********************************************************************
// host side of the SD controller: buffer geometry, word types and
// the request/status level bundles seen by the host
//**********************************************************************
`default_nettype none

package host_pkg;

   localparam int WORD_BITS        = 16;
   localparam int WORDS_PER_SECTOR = 256;   // 512 bytes

   typedef logic [WORD_BITS-1:0] word_t;
   typedef logic [7:0]           word_addr_t;    // word index in a sector
   typedef logic [26:0]          sector_addr_t;  // block address on the card

   // request levels, held by the host
   typedef struct packed {
      logic read_start;
      logic write_start;
      logic read_ack;
      logic write_ack;
   } host_req_t;

   typedef struct packed {
      logic idle;
      logic read_done;
      logic write_done;
      logic error;          // sticky until next start
   } host_status_t;

endpackage

`default_nettype wire

// ==== logic/sd_pkg.sv ====
//**********************************************************************
// SPI-mode protocol values: command frame, R1, tokens, timeouts and
// the SCLK divider setting
//**********************************************************************
`default_nettype none

package sd_pkg;

   localparam int CMD_BITS = 48;
   localparam int R1_BITS  = 7;

   typedef logic [CMD_BITS-1:0] sd_cmd_t;
   typedef logic [R1_BITS-1:0]  r1_t;

   //*******************************************************************
   // command bytes, start bit and transmission bit already included
   //*******************************************************************
   localparam logic [7:0] CMD_READ_BLOCK  = 8'h51;   // CMD17
   localparam logic [7:0] CMD_WRITE_BLOCK = 8'h58;   // CMD24
   localparam logic [7:0] CMD_TAIL        = 8'h01;   // dummy crc + stop bit

   localparam int R1_TIMEOUT = 1023;    // bit times before giving up on R1

   // data response token xxx0sss1, low nibble when accepted
   localparam logic [3:0] DATA_RESP_OK   = 4'b0101;
   localparam int         DATA_RESP_BITS = 8;

   localparam int START_GAP_BITS = 7;   // ones ahead of the 0 start bit
   localparam int CRC_BITS       = 16;

   // controller_clk cycles per half SCLK period
   localparam int SCLK_HALF = 2;

endpackage

`default_nettype wire

// ==== logic/sd_sequencer.sv ====
//**********************************************************************
// command / response / data block FSM for CMD17 and CMD24, one wire
// bit per bit_tick, plus the start/done/ack level handshake to the host
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module sd_sequencer
   import host_pkg::*;
   import sd_pkg::*;
(
   input  wire logic         controller_clk,
   input  wire logic         reset,
   input  wire host_req_t    req,
   input  wire sector_addr_t sector_addr,
   input  wire logic         bit_tick,
   input  wire logic         rx_bit,
   input  wire word_t        card_word_out,
   output host_status_t      status,
   output logic              tx_bit,
   output logic              sdcard_cs,
   output word_addr_t        card_index,
   output logic              card_store,
   output word_t             card_word_in
);

   typedef enum logic [3:0] {
      idle, send_cmd, r1_wait, r1_read, read_token_wait, read_data, read_crc,
      write_gap, write_data, write_crc, data_resp, busy_wait, wait_ack, fault
   } state_t;

   state_t     state;
   sd_cmd_t    cmd;          // frame being shifted out
   r1_t        r1;
   logic [9:0] count;        // bit counter and R1 timeout
   word_t      shift;        // data word / response shifter
   logic       is_write;
   logic       read_done;
   logic       write_done;
   logic       error;
   word_t      rx_word;
   r1_t        r1_next;
   word_t      tx_word;
   logic       last_word;

   //*******************************************************************
   // datapath helpers for the low byte first, msb first wire order
   //*******************************************************************
   always_comb begin
      rx_word   = {shift[WORD_BITS-2:0], rx_bit};
      r1_next   = {r1[R1_BITS-2:0], rx_bit};
      tx_word   = {card_word_out[7:0], card_word_out[15:8]};
      last_word = (card_index == word_addr_t'(WORDS_PER_SECTOR - 1));
   end

   assign card_word_in = {rx_word[7:0], rx_word[15:8]};
   assign card_store   = bit_tick && (state == read_data) && (count == '0);

   always_comb begin
      status.idle       = (state == idle) && !req.read_start && !req.write_start;
      status.read_done  = read_done;
      status.write_done = write_done;
      status.error      = error;
   end

   //*******************************************************************
   // main FSM
   //*******************************************************************
   always_ff @(posedge controller_clk) begin
      if (reset) begin
         state      <= idle;
         sdcard_cs  <= 1'b1;
         tx_bit     <= 1'b1;
         count      <= '0;
         card_index <= '0;
         is_write   <= 1'b0;
         read_done  <= 1'b0;
         write_done <= 1'b0;
         error      <= 1'b0;
      end
      else begin
         case (state)
            idle: if (req.read_start || req.write_start) begin
               is_write   <= !req.read_start;   // read wins a tie
               cmd        <= {req.read_start ? CMD_READ_BLOCK : CMD_WRITE_BLOCK,
                              5'b00000, sector_addr, CMD_TAIL};
               count      <= 10'(CMD_BITS - 1);
               card_index <= '0;
               error      <= 1'b0;
               sdcard_cs  <= 1'b0;
               state      <= send_cmd;
            end
            send_cmd: if (bit_tick) begin
               tx_bit <= cmd[CMD_BITS-1];
               cmd    <= {cmd[CMD_BITS-2:0], 1'b1};
               count  <= count - 10'd1;
               if (count == '0) begin
                  count <= 10'(R1_TIMEOUT);
                  state <= r1_wait;
               end
            end
            r1_wait: if (bit_tick) begin
               tx_bit <= 1'b1;
               count  <= count - 10'd1;
               if (!rx_bit) begin           // R1 start bit
                  count <= 10'(R1_BITS - 1);
                  state <= r1_read;
               end
               else if (count == '0)
                  state <= fault;
            end
            r1_read: if (bit_tick) begin
               r1    <= r1_next;
               count <= count - 10'd1;
               if (count == '0) begin
                  count <= 10'(START_GAP_BITS);
                  if (r1_next != '0)
                     state <= fault;
                  else
                     state <= is_write ? write_gap : read_token_wait;
               end
            end
            // the only zero of the 0xFE token is its last bit
            read_token_wait: if (bit_tick && !rx_bit) begin
               count <= 10'(WORD_BITS - 1);
               state <= read_data;
            end
            read_data: if (bit_tick) begin
               shift <= rx_word;
               count <= count - 10'd1;
               if (count == '0) begin        // word stored by card_store
                  count <= 10'(WORD_BITS - 1);
                  if (last_word) begin
                     count <= 10'(CRC_BITS - 1);
                     state <= read_crc;
                  end
                  else
                     card_index <= card_index + 8'd1;
               end
            end
            read_crc: if (bit_tick) begin   // crc ignored
               count <= count - 10'd1;
               if (count == '0) begin
                  read_done <= 1'b1;
                  sdcard_cs <= 1'b1;
                  state     <= wait_ack;
               end
            end
            write_gap: if (bit_tick) begin
               tx_bit <= (count != '0);     // ones then the 0 start bit
               count  <= count - 10'd1;
               if (count == '0) begin
                  count <= 10'(WORD_BITS - 1);
                  state <= write_data;
               end
            end
            write_data: if (bit_tick) begin
               if (count == 10'(WORD_BITS - 1)) begin   // fresh word
                  tx_bit <= tx_word[WORD_BITS-1];
                  shift  <= {tx_word[WORD_BITS-2:0], 1'b0};
               end
               else begin
                  tx_bit <= shift[WORD_BITS-1];
                  shift  <= {shift[WORD_BITS-2:0], 1'b0};
               end
               count <= count - 10'd1;
               if (count == '0) begin
                  count <= 10'(WORD_BITS - 1);
                  if (last_word) begin
                     count <= 10'(CRC_BITS - 1);
                     state <= write_crc;
                  end
                  else
                     card_index <= card_index + 8'd1;
               end
            end
            write_crc: if (bit_tick) begin
               tx_bit <= 1'b0;              // dummy crc
               count  <= count - 10'd1;
               if (count == '0) begin
                  count <= 10'(DATA_RESP_BITS);  // one extra as the first sample is stale
                  state <= data_resp;
               end
            end
            data_resp: if (bit_tick) begin
               tx_bit <= 1'b1;
               shift  <= rx_word;
               count  <= count - 10'd1;
               if (count == '0)
                  state <= (rx_word[3:0] == DATA_RESP_OK) ? busy_wait : fault;
            end
            busy_wait: if (bit_tick && rx_bit) begin   // card releases busy
               write_done <= 1'b1;
               sdcard_cs  <= 1'b1;
               state      <= wait_ack;
            end
            wait_ack: begin
               if (req.read_ack)
                  read_done <= 1'b0;
               if (req.write_ack)
                  write_done <= 1'b0;
               if (!(req.read_start || req.write_start || req.read_ack || req.write_ack))
                  state <= idle;
            end
            fault: begin
               error     <= 1'b1;
               sdcard_cs <= 1'b1;
               state     <= wait_ack;   // hold off until the host drops its request
            end
            default: state <= idle;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/sdspi_top.sv ====
//**********************************************************************
// SD card controller, SPI mode, one 512-byte sector per request
// host fills/reads the sector buffers and runs CMD17/CMD24 by levels
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module sdspi_top
   import host_pkg::*;
(
   input  wire logic         controller_clk,
   input  wire logic         reset,
   input  wire host_req_t    req,
   input  wire sector_addr_t sector_addr,
   input  wire word_addr_t   xfer_addr,
   input  wire logic         xfer_write,
   input  wire word_t        xfer_in,
   input  wire logic         sdcard_miso,
   output host_status_t      status,
   output word_t             xfer_out,
   output logic              sdcard_cs,
   output logic              sdcard_mosi,
   output logic              sdcard_sclk
);

   logic       bit_tick;
   logic       rx_bit;
   logic       tx_bit;
   word_addr_t card_index;
   logic       card_store;
   word_t      card_word_in;
   word_t      card_word_out;

   sector_buffer sector_buffer_inst (
      .controller_clk, .xfer_addr, .xfer_write, .xfer_in, .xfer_out,
      .card_index, .card_store, .card_word_in, .card_word_out
   );

   spi_link spi_link_inst (
      .controller_clk, .reset, .tx_bit, .sdcard_miso,
      .bit_tick, .rx_bit, .sdcard_sclk, .sdcard_mosi
   );

   sd_sequencer sd_sequencer_inst (
      .controller_clk, .reset, .req, .sector_addr, .bit_tick, .rx_bit,
      .card_word_out, .status, .tx_bit, .sdcard_cs, .card_index,
      .card_store, .card_word_in
   );

endmodule

`default_nettype wire

// ==== logic/sector_buffer.sv ====
//**********************************************************************
// read and write sector memories, host word port on one side and
// the sequencer's card word port on the other
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module sector_buffer
   import host_pkg::*;
(
   input  wire logic       controller_clk,
   input  wire word_addr_t xfer_addr,
   input  wire logic       xfer_write,
   input  wire word_t      xfer_in,
   input  wire word_addr_t card_index,
   input  wire logic       card_store,
   input  wire word_t      card_word_in,
   output word_t           xfer_out,
   output word_t           card_word_out
);

   word_t read_mem  [WORDS_PER_SECTOR];   // filled from the card
   word_t write_mem [WORDS_PER_SECTOR];   // filled by the host

   // host side
   always_ff @(posedge controller_clk) begin
      xfer_out <= read_mem[xfer_addr];      // one cycle latency
      if (xfer_write)
         write_mem[xfer_addr] <= xfer_in;
   end

   // card side
   always_ff @(posedge controller_clk) begin
      if (card_store)
         read_mem[card_index] <= card_word_in;
   end

   assign card_word_out = write_mem[card_index];   // async fetch for tx

endmodule

`default_nettype wire

// ==== logic/spi_link.sv ====
//**********************************************************************
// SPI bit timing: free running SCLK from controller_clk, MISO sampled
// with a bit_tick on the rising edge, tx_bit launched on the falling
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module spi_link
   import sd_pkg::*;
(
   input  wire logic controller_clk,
   input  wire logic reset,
   input  wire logic tx_bit,
   input  wire logic sdcard_miso,
   output logic       bit_tick,
   output logic       rx_bit,
   output logic       sdcard_sclk,
   output logic       sdcard_mosi
);

   logic [3:0] div_cnt;   // cycles into the current half period

   always_ff @(posedge controller_clk) begin
      if (reset) begin
         div_cnt     <= '0;
         sdcard_sclk <= 1'b0;
         sdcard_mosi <= 1'b1;   // idle line is high
         bit_tick    <= 1'b0;
      end
      else begin
         bit_tick <= 1'b0;
         if (div_cnt == 4'(SCLK_HALF - 1)) begin
            div_cnt     <= '0;
            sdcard_sclk <= ~sdcard_sclk;
            if (!sdcard_sclk) begin
               // rising edge, card data is stable here
               rx_bit   <= sdcard_miso;
               bit_tick <= 1'b1;
            end
            else begin
               sdcard_mosi <= tx_bit;   // falling edge launch
            end
         end
         else begin
            div_cnt <= div_cnt + 4'd1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verif/sd_card_model.sv ====
//**********************************************************************
// behavioral SPI-mode card for CMD17/CMD24, samples MOSI on rising
// SCLK and shifts MISO on falling SCLK; fault knobs on its ports
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module sd_card_model
   import host_pkg::*;
   import sd_pkg::*;
(
   input  wire logic       sdcard_cs,
   input  wire logic       sdcard_sclk,
   input  wire logic       sdcard_mosi,
   input  wire logic [7:0] r1_value,      // R1 to answer with
   input  wire logic       no_r1,         // stay silent after a command
   input  wire logic       reject_data,   // answer a block with a crc error
   output logic            sdcard_miso
);

   localparam int SECTOR_BYTES = 2 * WORDS_PER_SECTOR;
   localparam int DATA_BITS    = 8 * SECTOR_BYTES;

   typedef enum int {hunt, cmd_rx, ignore, data_hunt, data_rx} card_mode_t;

   card_mode_t mode;
   logic       tx_queue [$];               // bits waiting for MISO
   logic [7:0] read_block  [SECTOR_BYTES];  // served on CMD17
   logic [7:0] write_block [SECTOR_BYTES];  // captured on CMD24
   sd_cmd_t    last_cmd;
   sd_cmd_t    frame;
   int         bit_cnt;
   logic [7:0] rx_byte;

   task automatic push_byte(input logic [7:0] b);
      for (int i = 7; i >= 0; i--)
         tx_queue.push_back(b[i]);
   endtask

   task automatic answer_command();
      last_cmd = frame;
      mode     = ignore;
      if (!no_r1) begin
         push_byte(8'hFF);   // Ncr gap
         push_byte(r1_value);
         if (r1_value == 8'h00) begin
            if (frame[47:40] == CMD_READ_BLOCK) begin
               push_byte(8'hFF);
               push_byte(8'hFE);   // start token
               for (int i = 0; i < SECTOR_BYTES; i++)
                  push_byte(read_block[i]);
               push_byte(8'hFF);   // crc, not checked
               push_byte(8'hFF);
            end
            else
               mode = data_hunt;
         end
      end
   endtask

   initial begin
      sdcard_miso = 1'b1;
      mode        = hunt;
      last_cmd    = '0;
   end

   //*******************************************************************
   // receive side
   //*******************************************************************
   always @(posedge sdcard_sclk) begin
      if (sdcard_cs) begin   // deselected, forget everything
         mode = hunt;
         tx_queue.delete();
      end
      else begin
         case (mode)
            hunt: if (!sdcard_mosi) begin   // frame start bit
               frame   = '0;
               bit_cnt = 1;
               mode    = cmd_rx;
            end
            cmd_rx: begin
               frame   = {frame[46:0], sdcard_mosi};
               bit_cnt = bit_cnt + 1;
               if (bit_cnt == CMD_BITS)
                  answer_command();
            end
            data_hunt: if (!sdcard_mosi) begin   // last bit of 0xFE
               bit_cnt = 0;
               mode    = data_rx;
            end
            data_rx: begin
               rx_byte = {rx_byte[6:0], sdcard_mosi};
               bit_cnt = bit_cnt + 1;
               if (bit_cnt <= DATA_BITS && bit_cnt % 8 == 0)
                  write_block[bit_cnt/8 - 1] = rx_byte;
               if (bit_cnt == DATA_BITS + CRC_BITS) begin
                  push_byte(reject_data ? 8'hEB : 8'hE5);
                  if (!reject_data) begin
                     push_byte(8'h00);   // busy
                     push_byte(8'h00);
                  end
                  mode = ignore;
               end
            end
            default: ;
         endcase
      end
   end

   // transmit side, line idles high
   always @(negedge sdcard_sclk) begin
      if (sdcard_cs || tx_queue.size() == 0)
         sdcard_miso <= 1'b1;
      else
         sdcard_miso <= tx_queue.pop_front();
   end

endmodule

`default_nettype wire

// ==== verif/sdspi_assert.sv ====
//**********************************************************************
// concurrent checks bound onto the controller's top level ports
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module sdspi_assert
   import host_pkg::*;
(
   input wire logic         controller_clk,
   input wire logic         reset,
   input wire host_status_t status,
   input wire logic         sdcard_cs
);

   int failures = 0;   // count of failed assertions

   cs_idle: assert property (@(posedge controller_clk) disable iff (reset)
      status.idle |-> sdcard_cs)
      else begin
         failures++;
         $error("card selected while controller idle");
      end

   error_excl: assert property (@(posedge controller_clk) disable iff (reset)
      !(status.error && (status.read_done || status.write_done)))
      else begin
         failures++;
         $error("error flag together with a done");
      end

   done_excl: assert property (@(posedge controller_clk) disable iff (reset)
      !(status.read_done && status.write_done))
      else begin
         failures++;
         $error("read_done and write_done both high");
      end

endmodule

bind sdspi_top sdspi_assert sdspi_assert_inst (
   .controller_clk(controller_clk),
   .reset(reset),
   .status(status),
   .sdcard_cs(sdcard_cs)
);

`default_nettype wire

// ==== verif/tb_clock.sv ====
//**********************************************************************
// testbench clock and reset, 20 ns period, reset held for 3 cycles
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic controller_clk,
   output logic reset
);

   initial begin
      controller_clk = 1'b0;
      forever #10 controller_clk = ~controller_clk;
   end

   initial begin
      reset = 1'b1;
      repeat (3) @(posedge controller_clk);
      #2 reset = 1'b0;   // released off the edge like other inputs
   end

endmodule

`default_nettype wire

// ==== verif/tb_sdspi.sv ====
//**********************************************************************
// directed testbench for the SPI-mode SD controller with a card model
// on its pins; one line per test and a closing summary
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_sdspi
   import host_pkg::*;
   import sd_pkg::*;
;

   localparam int NUM_TESTS = 8;
   localparam int LIMIT     = NUM_TESTS * (48 + R1_TIMEOUT + 4200) * 2 * SCLK_HALF + 40000;

   logic         controller_clk;
   logic         reset;
   host_req_t    req;
   sector_addr_t sector_addr;
   word_addr_t   xfer_addr;
   logic         xfer_write;
   word_t        xfer_in;
   host_status_t status;
   word_t        xfer_out;
   logic         sdcard_cs;
   logic         sdcard_mosi;
   logic         sdcard_sclk;
   logic         sdcard_miso;
   logic [7:0]   r1_value;
   logic         no_r1;
   logic         reject_data;

   int           errors;
   int           checks;
   int           tests;
   int           test_start_errors;
   int           cycles;
   logic [31:0]  rng_state;
   word_t        sent_words [WORDS_PER_SECTOR];

   tb_clock tb_clock_inst (.controller_clk, .reset);

   sdspi_top sdspi_top_inst (
      .controller_clk, .reset, .req, .sector_addr, .xfer_addr, .xfer_write,
      .xfer_in, .sdcard_miso, .status, .xfer_out, .sdcard_cs, .sdcard_mosi,
      .sdcard_sclk
   );

   sd_card_model card_inst (
      .sdcard_cs, .sdcard_sclk, .sdcard_mosi, .r1_value, .no_r1,
      .reject_data, .sdcard_miso
   );

   //*******************************************************************
   // helpers
   //*******************************************************************
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic host_status_t make_status(input logic i, r, w, e);
      host_status_t s;
      s.idle       = i;
      s.read_done  = r;
      s.write_done = w;
      s.error      = e;
      return s;
   endfunction

   // compare failures plus failed bound assertions
   function automatic int error_count();
      return errors + sdspi_top_inst.sdspi_assert_inst.failures;
   endfunction

   task automatic step();   // inputs change 2 ns after the edge
      @(posedge controller_clk);
      #2;
   endtask

   task automatic compare_word(input word_t got, input word_t exp, input string what);
      checks++;
      if (got !== exp) begin
         $display("Fail at %0d ns: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic compare_status(input host_status_t got, input host_status_t exp,
                                 input string what);
      checks++;
      if (got !== exp) begin
         $display("Fail at %0d ns: %s status got %b expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic compare_cmd(input sd_cmd_t got, input sd_cmd_t exp, input string what);
      checks++;
      if (got !== exp) begin
         $display("Fail at %0d ns: %s frame got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic compare_bit(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         $display("Fail at %0d ns: %s got %b expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic begin_test();
      test_start_errors = error_count();
      tests++;
   endtask

   task automatic end_test(input string name);
      $display("test %-12s %s", name, (error_count() == test_start_errors) ? "ok" : "failed");
   endtask

   task automatic start_transfer(input logic do_write, input sector_addr_t addr);
      step();
      sector_addr     = addr;
      req.write_start = do_write;
      req.read_start  = !do_write;
   endtask

   task automatic wait_for_end();   // until a done or the error flag
      step();
      while (!(status.read_done || status.write_done || status.error))
         step();
   endtask

   // drop start, ack a done, then wait for idle
   task automatic release_transfer();
      step();
      req.read_start  = 1'b0;
      req.write_start = 1'b0;
      req.read_ack    = status.read_done;
      req.write_ack   = status.write_done;
      while (status.read_done || status.write_done)
         step();
      compare_bit(status.idle, 1'b0, "idle during ack");
      req.read_ack  = 1'b0;
      req.write_ack = 1'b0;
      while (!status.idle)
         step();
   endtask

   task automatic load_card_block();
      for (int i = 0; i < 2 * WORDS_PER_SECTOR; i++) begin
         rng_state             = xorshift(rng_state);
         card_inst.read_block[i] = rng_state[7:0];
      end
   endtask

   task automatic check_read_buffer();
      word_t exp;
      for (int i = 0; i < WORDS_PER_SECTOR; i++) begin
         step();
         xfer_addr = word_addr_t'(i);
         step();
         exp = {card_inst.read_block[2*i+1], card_inst.read_block[2*i]};
         compare_word(xfer_out, exp, "read buffer word");
      end
   endtask

   //*******************************************************************
   // directed tests
   //*******************************************************************
   task automatic test_reset();
      begin_test();
      step();
      compare_status(status, make_status(1, 0, 0, 0), "after reset");
      compare_bit(sdcard_cs, 1'b1, "cs after reset");
      compare_bit(sdcard_mosi, 1'b1, "mosi after reset");
      end_test("reset");
   endtask

   task automatic test_write(input sector_addr_t addr);
      word_t got;
      begin_test();
      for (int i = 0; i < WORDS_PER_SECTOR; i++) begin
         rng_state      = xorshift(rng_state);
         sent_words[i]  = rng_state[15:0];
         step();
         xfer_addr  = word_addr_t'(i);
         xfer_in    = sent_words[i];
         xfer_write = 1'b1;
      end
      step();
      xfer_write = 1'b0;
      start_transfer(1'b1, addr);
      wait_for_end();
      compare_status(status, make_status(0, 0, 1, 0), "write end");
      repeat (20) step();
      compare_bit(status.write_done, 1'b1, "write_done held");
      compare_cmd(card_inst.last_cmd, {CMD_WRITE_BLOCK, 5'b00000, addr, CMD_TAIL}, "CMD24");
      for (int i = 0; i < WORDS_PER_SECTOR; i++) begin
         got = {card_inst.write_block[2*i+1], card_inst.write_block[2*i]};
         compare_word(got, sent_words[i], "card block word");
      end
      release_transfer();
      end_test("write");
   endtask

   task automatic test_read(input sector_addr_t addr, input string name);
      begin_test();
      load_card_block();
      start_transfer(1'b0, addr);
      wait_for_end();
      compare_status(status, make_status(0, 1, 0, 0), "read end");
      compare_cmd(card_inst.last_cmd, {CMD_READ_BLOCK, 5'b00000, addr, CMD_TAIL}, "CMD17");
      release_transfer();
      compare_status(status, make_status(1, 0, 0, 0), "after read");
      check_read_buffer();
      end_test(name);
   endtask

   task automatic test_handshake();
      begin_test();
      load_card_block();
      start_transfer(1'b0, 27'h0000042);
      wait_for_end();
      repeat (300) begin   // start held high with no ack
         step();
         compare_bit(status.read_done, 1'b1, "done without ack");
      end
      req.read_ack = 1'b1;
      while (status.read_done)
         step();
      repeat (10) begin
         step();
         compare_status(status, make_status(0, 0, 0, 0), "start and ack high");
      end
      req.read_start = 1'b0;
      repeat (50) begin
         step();
         compare_status(status, make_status(0, 0, 0, 0), "start low, ack high");
      end
      req.read_ack = 1'b0;
      step();
      step();
      compare_status(status, make_status(1, 0, 0, 0), "back to idle");
      end_test("handshake");
   endtask

   task automatic test_fault(input logic do_write, input string name);
      begin_test();
      start_transfer(do_write, 27'h1ABCDEF);
      wait_for_end();
      compare_status(status, make_status(0, 0, 0, 1), "fault end");
      release_transfer();
      compare_status(status, make_status(1, 0, 0, 1), "idle after fault");
      r1_value    = 8'h00;
      no_r1       = 1'b0;
      reject_data = 1'b0;
      end_test(name);
   endtask

   //*******************************************************************
   // watchdog
   //*******************************************************************
   always @(posedge controller_clk) begin
      cycles <= cycles + 1;
      if (cycles > LIMIT) begin
         $display("timeout: the DUT did not finish within %0d cycles", LIMIT);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   initial begin
      req         = '0;
      sector_addr = '0;
      xfer_addr   = '0;
      xfer_write  = 1'b0;
      xfer_in     = '0;
      r1_value    = 8'h00;
      no_r1       = 1'b0;
      reject_data = 1'b0;
      errors      = 0;
      checks      = 0;
      tests       = 0;
      cycles      = 0;
      rng_state   = 32'd1;
      @(negedge reset);

      test_reset();
      test_write(27'h0123456);
      test_read(27'h7654321, "read");
      test_handshake();
      r1_value = 8'h04;   // illegal command
      test_fault(1'b0, "r1_error");
      no_r1 = 1'b1;
      test_fault(1'b0, "no_r1");
      reject_data = 1'b1;
      test_fault(1'b1, "data_reject");
      test_read(27'h0000001, "recovery");   // error must clear on start

      $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, error_count());
      if (error_count() == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire
